/* Makefile */
TOP = tb_matrix_calc

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@if grep -q "Errors found" sim.log; then echo "FAIL"; exit 1; fi
	@grep -q "No errors" sim.log || (echo "FAIL: no result in sim.log"; exit 1)
	@echo "PASS"

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* button_debounce.sv */
// ==================================================
// Button debounce
// One clean press pulse per stable button press
// ==================================================
`include "matrix_cfg.svh"

module button_debounce (
    input  logic clk,
    input  logic rst_n,
    input  logic btn_in,
    output logic btn_pulse
);

    localparam int CW = $clog2(`MATRIX_DEBOUNCE_CYCLES);

    logic [1:0]    sync;
    logic          stable;
    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync      <= 2'b00;
            stable    <= 1'b0;
            cnt       <= '0;
            btn_pulse <= 1'b0;
        end else begin
            sync      <= {sync[0], btn_in};
            btn_pulse <= 1'b0;
            if (sync[1] == stable) begin
                cnt <= '0;
            end else if (cnt == CW'(`MATRIX_DEBOUNCE_CYCLES - 1)) begin
                // New level held long enough, pulse only on a press
                cnt       <= '0;
                stable    <= sync[1];
                btn_pulse <= sync[1];
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* matrix_calc_assert.sv */
// ==================================================
// Matrix store port assertions
// Mode LEDs, transmit mode and confirm press rules
// ==================================================
module matrix_calc_assert (
    input logic       clk,
    input logic       rst_n,
    input logic       btn_confirm,
    input logic       btn_back,
    input logic       uart_tx,
    input logic [3:0] led_status
);
    timeunit 1ns;
    timeprecision 100ps;

    logic       fail_onehot = 1'b0;
    logic       fail_tx_mode = 1'b0;
    logic       fail_press = 1'b0;
    logic       any_fail;
    logic [2:0] mode_q;
    logic       mode_chg;
    logic       press_chg;

    assign any_fail = fail_onehot || fail_tx_mode || fail_press;
    assign mode_chg = led_status[2:0] != mode_q;

    // Remembers a mode change during the current confirm press
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q    <= 3'b001;
            press_chg <= 1'b0;
        end else begin
            mode_q <= led_status[2:0];
            if (!btn_confirm) begin
                press_chg <= 1'b0;
            end else if (mode_chg) begin
                press_chg <= 1'b1;
            end
        end
    end

    one_mode: assert property (@(posedge clk) disable iff (!rst_n) $onehot(led_status[2:0]))
        else begin
            fail_onehot = 1'b1;
            $error("led_status does not show exactly one mode");
        end

    // Start bits only while readout is the mode
    tx_mode: assert property (@(posedge clk) disable iff (!rst_n) $fell(uart_tx) |-> led_status[2])
        else begin
            fail_tx_mode = 1'b1;
            $error("Start bit on uart_tx outside readout mode");
        end

    single_change: assert property (@(posedge clk) disable iff (!rst_n)
        !(btn_confirm && !btn_back && press_chg && mode_chg))
        else begin
            fail_press = 1'b1;
            $error("One confirm press changed the mode twice");
        end

endmodule

/* matrix_calc_top.sv */
// ==================================================
// Matrix store top level
// Buttons and UART in, entry and readout, status out
// ==================================================
module matrix_calc_top import matrix_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] dip_sw,
    input  logic       btn_confirm,
    input  logic       btn_back,
    input  logic       uart_rx,
    output logic       uart_tx,
    output logic [6:0] seg_display,
    output logic [3:0] led_status
);

    logic       confirm_pulse;
    logic       back_pulse;
    elem_t      rx_data;
    logic       rx_done;
    elem_t      tx_data;
    logic       tx_start;
    logic       tx_busy;
    logic       entry_active;
    logic       readout_active;
    err_e       entry_err;
    err_e       readout_err;
    slot_t      alloc_slot;
    logic       store_full;
    mem_wr_t    wr;
    logic       commit;
    slot_t      commit_slot;
    mat_dims_t  commit_dims;
    slot_t      query_slot;
    slot_info_t slot_info;
    mem_rd_t    rd;
    elem_t      rd_data;

    // ================================================
    // Input side
    // ================================================
    button_debounce u_db_confirm (
        .clk       (clk),
        .rst_n     (rst_n),
        .btn_in    (btn_confirm),
        .btn_pulse (confirm_pulse)
    );

    button_debounce u_db_back (
        .clk       (clk),
        .rst_n     (rst_n),
        .btn_in    (btn_back),
        .btn_pulse (back_pulse)
    );

    // Receive feeds both modes, only readout transmits
    uart_link u_uart (
        .clk      (clk),
        .rst_n    (rst_n),
        .uart_rx  (uart_rx),
        .rx_data  (rx_data),
        .rx_done  (rx_done),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .uart_tx  (uart_tx)
    );

    // ================================================
    // Processing
    // ================================================
    mode_control u_mode (
        .clk            (clk),
        .rst_n          (rst_n),
        .dip_sw         (dip_sw),
        .confirm_pulse  (confirm_pulse),
        .back_pulse     (back_pulse),
        .entry_err      (entry_err),
        .readout_err    (readout_err),
        .entry_active   (entry_active),
        .readout_active (readout_active),
        .seg_display    (seg_display),
        .led_status     (led_status)
    );

    matrix_entry u_entry (
        .clk         (clk),
        .rst_n       (rst_n),
        .active      (entry_active),
        .rx_data     (rx_data),
        .rx_done     (rx_done),
        .alloc_slot  (alloc_slot),
        .store_full  (store_full),
        .wr          (wr),
        .commit      (commit),
        .commit_slot (commit_slot),
        .commit_dims (commit_dims),
        .err         (entry_err)
    );

    matrix_readout u_readout (
        .clk        (clk),
        .rst_n      (rst_n),
        .active     (readout_active),
        .rx_data    (rx_data),
        .rx_done    (rx_done),
        .query_slot (query_slot),
        .slot_info  (slot_info),
        .rd         (rd),
        .rd_data    (rd_data),
        .tx_data    (tx_data),
        .tx_start   (tx_start),
        .tx_busy    (tx_busy),
        .err        (readout_err)
    );

    matrix_store u_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc_slot  (alloc_slot),
        .store_full  (store_full),
        .wr          (wr),
        .commit      (commit),
        .commit_slot (commit_slot),
        .commit_dims (commit_dims),
        .query_slot  (query_slot),
        .slot_info   (slot_info),
        .rd          (rd),
        .rd_data     (rd_data)
    );

endmodule

/* matrix_cfg.svh */
// ==================================================
// Matrix store configuration
// UART timing, button and error timing, store sizes
// ==================================================
`ifndef MATRIX_CFG_SVH
`define MATRIX_CFG_SVH

// UART bit period in clocks, kept short for simulation
`define MATRIX_CLKS_PER_BIT     16

// Stable clocks before a button press is accepted
`define MATRIX_DEBOUNCE_CYCLES  16

// Clocks the error LED stays lit after the last error
`define MATRIX_ERR_HOLD_CYCLES  200

// Largest row or column count
`define MATRIX_MAX_DIM          4

// Number of matrices held in the store
`define MATRIX_SLOTS            4

`endif

/* matrix_entry.sv */
// ==================================================
// Matrix entry
// Takes rows, cols and elements over UART into the store
// ==================================================
`include "matrix_cfg.svh"

module matrix_entry import matrix_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      active,
    input  elem_t     rx_data,
    input  logic      rx_done,
    input  slot_t     alloc_slot,
    input  logic      store_full,
    output mem_wr_t   wr,
    output logic      commit,
    output slot_t     commit_slot,
    output mat_dims_t commit_dims,
    output err_e      err
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_ROWS, ST_COLS, ST_ELEMS, ST_COMMIT, ST_WAIT
    } state_e;

    state_e     state;
    slot_t      slot;
    mat_dims_t  dims;
    idx_t       cnt;
    logic       alloc_req;
    logic       dim_bad;
    logic [4:0] last_idx;

    // Store answers the allocation in the same cycle
    // Slot table only updates the cycle after a commit
    assign alloc_req   = active && state == ST_IDLE && !commit && !store_full;
    assign dim_bad     = rx_data == '0 || rx_data > elem_t'(`MATRIX_MAX_DIM);
    assign last_idx    = 5'(dims.rows) * 5'(dims.cols) - 5'd1;
    assign commit_slot = slot;
    assign commit_dims = dims;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            slot   <= '0;
            dims   <= '0;
            cnt    <= '0;
            wr     <= '0;
            commit <= 1'b0;
            err    <= ERR_NONE;
        end else begin
            wr.en  <= 1'b0;
            commit <= 1'b0;
            err    <= ERR_NONE;
            if (!active) begin
                state <= ST_IDLE;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (alloc_req) begin
                            slot  <= alloc_slot;
                            state <= ST_ROWS;
                        end else if (!commit) begin
                            err   <= ERR_FULL;
                            state <= ST_WAIT;
                        end
                    end
                    ST_ROWS: begin
                        if (rx_done && dim_bad) begin
                            err <= ERR_BAD_DIM;
                        end else if (rx_done) begin
                            dims.rows <= dim_t'(rx_data);
                            state     <= ST_COLS;
                        end
                    end
                    ST_COLS: begin
                        // A bad column count restarts from rows
                        if (rx_done && dim_bad) begin
                            err   <= ERR_BAD_DIM;
                            state <= ST_ROWS;
                        end else if (rx_done) begin
                            dims.cols <= dim_t'(rx_data);
                            cnt       <= '0;
                            state     <= ST_ELEMS;
                        end
                    end
                    ST_ELEMS: begin
                        if (rx_done) begin
                            wr <= '{en: 1'b1, slot: slot, idx: cnt, data: rx_data};
                            if ({1'b0, cnt} == last_idx) begin
                                state <= ST_COMMIT;
                            end else begin
                                cnt <= cnt + 1'b1;
                            end
                        end
                    end
                    ST_COMMIT: begin
                        commit <= 1'b1;
                        state  <= ST_IDLE;
                    end
                    // Store full, hold until back
                    default: state <= ST_WAIT;
                endcase
            end
        end
    end

endmodule

/* matrix_pkg.sv */
// ==================================================
// Matrix store shared types
// Element, dimension and slot types plus bus structs
// ==================================================
package matrix_pkg;

    // One element, also one UART byte
    typedef logic [7:0] elem_t;
    typedef logic [2:0] dim_t;
    typedef logic [1:0] slot_t;
    // Element index inside a slot region
    typedef logic [3:0] idx_t;

    typedef struct packed {
        dim_t rows;
        dim_t cols;
    } mat_dims_t;

    typedef struct packed {
        logic  en;
        slot_t slot;
        idx_t  idx;
        elem_t data;
    } mem_wr_t;

    typedef struct packed {
        logic  en;
        slot_t slot;
        idx_t  idx;
    } mem_rd_t;

    typedef struct packed {
        logic      valid;
        mat_dims_t dims;
    } slot_info_t;

    typedef enum logic [1:0] {MODE_MENU, MODE_ENTRY, MODE_READOUT} mode_e;

    typedef enum logic [1:0] {ERR_NONE, ERR_BAD_DIM, ERR_FULL, ERR_EMPTY_SLOT} err_e;

endpackage

/* matrix_readout.sv */
// ==================================================
// Matrix readout
// Sends a stored matrix as rows, cols and elements
// ==================================================
module matrix_readout import matrix_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       active,
    input  elem_t      rx_data,
    input  logic       rx_done,
    output slot_t      query_slot,
    input  slot_info_t slot_info,
    output mem_rd_t    rd,
    input  elem_t      rd_data,
    output elem_t      tx_data,
    output logic       tx_start,
    input  logic       tx_busy,
    output err_e       err
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_CHECK, ST_ROWS, ST_COLS, ST_READ, ST_SEND
    } state_e;

    state_e     state;
    mat_dims_t  dims;
    idx_t       cnt;
    elem_t      hdr_byte;
    logic       send_hdr;
    logic       tx_ready;
    logic [4:0] last_idx;

    // tx_busy rises one cycle after tx_start, so mask that cycle
    assign tx_ready = !tx_busy && !tx_start;
    assign last_idx = 5'(dims.rows) * 5'(dims.cols) - 5'd1;
    // Element bytes come straight from the registered read
    assign tx_data  = send_hdr ? hdr_byte : rd_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            query_slot <= '0;
            dims       <= '0;
            cnt        <= '0;
            hdr_byte   <= '0;
            send_hdr   <= 1'b0;
            rd         <= '0;
            tx_start   <= 1'b0;
            err        <= ERR_NONE;
        end else begin
            rd.en    <= 1'b0;
            tx_start <= 1'b0;
            err      <= ERR_NONE;
            if (!active) begin
                state <= ST_IDLE;
            end else begin
                case (state)
                    ST_IDLE: begin
                        if (rx_done) begin
                            query_slot <= slot_t'(rx_data);
                            state      <= ST_CHECK;
                        end
                    end
                    ST_CHECK: begin
                        if (slot_info.valid) begin
                            dims  <= slot_info.dims;
                            state <= ST_ROWS;
                        end else begin
                            err   <= ERR_EMPTY_SLOT;
                            state <= ST_IDLE;
                        end
                    end
                    ST_ROWS: begin
                        if (tx_ready) begin
                            tx_start <= 1'b1;
                            send_hdr <= 1'b1;
                            hdr_byte <= elem_t'(dims.rows);
                            state    <= ST_COLS;
                        end
                    end
                    ST_COLS: begin
                        if (tx_ready) begin
                            tx_start <= 1'b1;
                            hdr_byte <= elem_t'(dims.cols);
                            cnt      <= '0;
                            state    <= ST_READ;
                        end
                    end
                    ST_READ: begin
                        if (tx_ready) begin
                            rd    <= '{en: 1'b1, slot: query_slot, idx: cnt};
                            state <= ST_SEND;
                        end
                    end
                    default: begin
                        tx_start <= 1'b1;
                        send_hdr <= 1'b0;
                        if ({1'b0, cnt} == last_idx) begin
                            state <= ST_IDLE;
                        end else begin
                            cnt   <= cnt + 1'b1;
                            state <= ST_READ;
                        end
                    end
                endcase
            end
        end
    end

endmodule

/* matrix_store.sv */
// ==================================================
// Matrix store
// Element block memory and per-slot valid and dims table
// ==================================================
`include "matrix_cfg.svh"

module matrix_store import matrix_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    output slot_t      alloc_slot,
    output logic       store_full,
    input  mem_wr_t    wr,
    input  logic       commit,
    input  slot_t      commit_slot,
    input  mat_dims_t  commit_dims,
    input  slot_t      query_slot,
    output slot_info_t slot_info,
    input  mem_rd_t    rd,
    output elem_t      rd_data
);

    localparam int DEPTH = `MATRIX_SLOTS * `MATRIX_MAX_DIM * `MATRIX_MAX_DIM;

    elem_t                    mem [DEPTH];
    logic [`MATRIX_SLOTS-1:0] slot_valid;
    mat_dims_t                slot_dims [`MATRIX_SLOTS];

    // Slot number forms the upper address bits
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[{wr.slot, wr.idx}] <= wr.data;
        end
        if (rd.en) begin
            rd_data <= mem[{rd.slot, rd.idx}];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid <= '0;
            for (int i = 0; i < `MATRIX_SLOTS; i++) begin
                slot_dims[i] <= '0;
            end
        end else if (commit) begin
            slot_valid[commit_slot] <= 1'b1;
            slot_dims[commit_slot]  <= commit_dims;
        end
    end

    // Lowest free slot
    always_comb begin
        alloc_slot = '0;
        for (int i = `MATRIX_SLOTS - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                alloc_slot = slot_t'(i);
            end
        end
    end

    assign store_full = &slot_valid;
    assign slot_info  = '{valid: slot_valid[query_slot], dims: slot_dims[query_slot]};

endmodule

/* mode_control.sv */
// ==================================================
// Mode control
// Main mode FSM, error hold timer, LEDs and mode digit
// ==================================================
`include "matrix_cfg.svh"

module mode_control import matrix_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] dip_sw,
    input  logic       confirm_pulse,
    input  logic       back_pulse,
    input  err_e       entry_err,
    input  err_e       readout_err,
    output logic       entry_active,
    output logic       readout_active,
    output logic [6:0] seg_display,
    output logic [3:0] led_status
);

    localparam int HW = $clog2(`MATRIX_ERR_HOLD_CYCLES + 1);

    mode_e         mode;
    mode_e         mode_next;
    logic [HW-1:0] hold_cnt;
    logic          err_led;

    always_comb begin
        mode_next = mode;
        case (mode)
            MODE_MENU: begin
                if (confirm_pulse && dip_sw == 3'd1) begin
                    mode_next = MODE_ENTRY;
                end else if (confirm_pulse && dip_sw == 3'd2) begin
                    mode_next = MODE_READOUT;
                end
            end
            default: begin
                if (back_pulse) begin
                    mode_next = MODE_MENU;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode     <= MODE_MENU;
            hold_cnt <= '0;
        end else begin
            mode <= mode_next;
            // Each new error restarts the hold window
            if (entry_err != ERR_NONE || readout_err != ERR_NONE) begin
                hold_cnt <= HW'(`MATRIX_ERR_HOLD_CYCLES);
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
        end
    end

    assign err_led        = hold_cnt != '0;
    assign entry_active   = mode == MODE_ENTRY;
    assign readout_active = mode == MODE_READOUT;
    assign led_status     = {err_led, readout_active, entry_active, mode == MODE_MENU};

    // Segment a is bit 0, g is bit 6
    always_comb begin
        case (mode)
            MODE_ENTRY:   seg_display = 7'b0000110;
            MODE_READOUT: seg_display = 7'b1011011;
            default:      seg_display = 7'b0111111;
        endcase
    end

endmodule

/* sim.f */
+incdir+.
matrix_pkg.sv
button_debounce.sv
uart_link.sv
matrix_store.sv
matrix_entry.sv
matrix_readout.sv
mode_control.sv
matrix_calc_top.sv
matrix_calc_assert.sv
tb_clk_gen.sv
tb_matrix_calc.sv

/* tb_clk_gen.sv */
// ==================================================
// Testbench clock and reset
// 8 ns clock, reset held low for the first cycles
// ==================================================
module tb_clk_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* tb_matrix_calc.sv */
// ==================================================
// Matrix store testbench
// UART driver and monitor, mode, entry and readout tests
// ==================================================
`include "matrix_cfg.svh"

module tb_matrix_calc;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SEED         = 53;
    localparam int CPB          = `MATRIX_CLKS_PER_BIT;
    localparam int FRAME_CYCLES = 11 * CPB;
    localparam int BTN_HOLD     = 2 * `MATRIX_DEBOUNCE_CYCLES + 8;
    localparam int ERR_HOLD     = `MATRIX_ERR_HOLD_CYCLES;
    localparam int MAX_ELEMS    = `MATRIX_MAX_DIM * `MATRIX_MAX_DIM;
    localparam int MAX_CYCLES   = 3 * 2 * (2 + MAX_ELEMS) * FRAME_CYCLES
                                + 16 * 2 * BTN_HOLD + 4 * ERR_HOLD;
    // Digit 1 lights segments b and c, a is bit 0
    localparam logic [6:0] SEG_ONE = 7'b0000110;

    logic       clk;
    logic       rst_n;
    logic [2:0] dip_sw;
    logic       btn_confirm;
    logic       btn_back;
    logic       uart_rx;
    logic       uart_tx;
    logic [6:0] seg_display;
    logic [3:0] led_status;

    logic [7:0] elems [2][MAX_ELEMS];
    int         rows_of [2] = '{2, 4};
    int         cols_of [2] = '{3, 4};
    logic [7:0] exp_q [$];
    int         cycles = 0;

    tb_clk_gen #(.PERIOD_NS(8), .RESET_CYCLES(3)) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    matrix_calc_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .dip_sw      (dip_sw),
        .btn_confirm (btn_confirm),
        .btn_back    (btn_back),
        .uart_rx     (uart_rx),
        .uart_tx     (uart_tx),
        .seg_display (seg_display),
        .led_status  (led_status)
    );

    bind matrix_calc_top matrix_calc_assert u_assert (
        .clk         (clk),
        .rst_n       (rst_n),
        .btn_confirm (btn_confirm),
        .btn_back    (btn_back),
        .uart_tx     (uart_tx),
        .led_status  (led_status)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic press_button(input bit back);
        @(posedge clk);
        if (back) begin
            btn_back <= 1'b1;
        end else begin
            btn_confirm <= 1'b1;
        end
        repeat (BTN_HOLD) @(posedge clk);
        btn_back    <= 1'b0;
        btn_confirm <= 1'b0;
        repeat (BTN_HOLD) @(posedge clk);
    endtask

    task automatic enter_mode(input logic [2:0] sw);
        @(posedge clk);
        dip_sw <= sw;
        press_button(1'b0);
    endtask

    // 8N1 frame, LSB first, one idle bit after the stop bit
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        @(posedge clk);
        for (int i = 0; i < 10; i++) begin
            uart_rx <= frame[i];
            repeat (CPB) @(posedge clk);
        end
        repeat (CPB) @(posedge clk);
    endtask

    task automatic check_status(input logic [3:0] exp_led, input string what);
        @(negedge clk);
        assert (led_status == exp_led) else
            report_failure($sformatf("MISMATCH at %0t ns: %s, led_status %b expected %b",
                                     $time, what, led_status, exp_led));
    endtask

    task automatic load_matrix(input int m);
        send_byte(8'(rows_of[m]));
        send_byte(8'(cols_of[m]));
        for (int i = 0; i < rows_of[m] * cols_of[m]; i++) begin
            send_byte(elems[m][i]);
        end
    endtask

    // Slots fill from 0, so matrix m sits in slot m
    task automatic expect_matrix(input int m);
        exp_q.push_back(8'(rows_of[m]));
        exp_q.push_back(8'(cols_of[m]));
        for (int i = 0; i < rows_of[m] * cols_of[m]; i++) begin
            exp_q.push_back(elems[m][i]);
        end
        send_byte(8'(m));
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic check_error_led(input string what);
        int lit;
        lit = 0;
        @(negedge clk);
        while (!led_status[3]) @(negedge clk);
        while (led_status[3]) begin
            lit++;
            @(negedge clk);
        end
        assert (lit <= ERR_HOLD + 4) else
            report_failure($sformatf("MISMATCH at %0t ns: %s, error LED lit %0d cycles",
                                     $time, what, lit));
    endtask

    // UART monitor, samples each bit at its middle
    initial begin
        logic [7:0] got;
        logic [7:0] exp;
        forever begin
            @(negedge clk);
            if (rst_n && uart_tx === 1'b0) begin
                repeat (CPB / 2) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CPB) @(negedge clk);
                    got[i] = uart_tx;
                end
                repeat (CPB) @(negedge clk);
                assert (uart_tx) else
                    report_failure("Stop bit on uart_tx was low");
                assert (exp_q.size() != 0) else
                    report_failure($sformatf("Unexpected byte %02h on uart_tx", got));
                exp = exp_q.pop_front();
                assert (got == exp) else
                    report_failure($sformatf("MISMATCH at %0t ns: uart_tx byte %02h expected %02h",
                                             $time, got, exp));
            end
        end
    end

    // Timeout and bound assertion watch
    always @(negedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            report_failure("Timeout, the run passed its cycle limit");
        end else if (UUT.u_assert.any_fail) begin
            report_failure("A bound assertion on the top ports failed");
        end
    end

    initial begin
        void'($urandom(SEED));
        dip_sw      <= 3'd0;
        btn_confirm <= 1'b0;
        btn_back    <= 1'b0;
        uart_rx     <= 1'b1;
        for (int m = 0; m < 2; m++) begin
            for (int i = 0; i < MAX_ELEMS; i++) begin
                elems[m][i] = 8'($urandom());
            end
        end
        @(posedge rst_n);
        repeat (2) @(posedge clk);

        // Reset state and a confirm that stays in menu
        check_status(4'b0001, "after reset");
        assert (uart_tx) else
            report_failure($sformatf("MISMATCH at %0t ns: uart_tx low after reset", $time));
        enter_mode(3'd0);
        check_status(4'b0001, "confirm with switch 0");

        // Entry mode and back
        enter_mode(3'd1);
        check_status(4'b0010, "confirm with switch 1");
        assert (seg_display == SEG_ONE) else
            report_failure($sformatf("MISMATCH at %0t ns: seg_display %b expected %b",
                                     $time, seg_display, SEG_ONE));
        press_button(1'b1);
        check_status(4'b0001, "back from entry");

        // Two matrices in one entry session, both read back
        enter_mode(3'd1);
        load_matrix(0);
        load_matrix(1);
        press_button(1'b1);
        enter_mode(3'd2);
        check_status(4'b0100, "confirm with switch 2");
        expect_matrix(0);
        expect_matrix(1);
        press_button(1'b1);

        // Bad column count, then an empty slot
        enter_mode(3'd1);
        send_byte(8'd2);
        send_byte(8'd5);
        check_error_led("column count 5");
        press_button(1'b1);
        enter_mode(3'd2);
        send_byte(8'd3);
        check_error_led("readout of empty slot 3");
        press_button(1'b1);
        check_status(4'b0001, "back to menu at the end");

        if (UUT.u_assert.any_fail) begin
            report_failure("A bound assertion on the top ports failed");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* uart_link.sv */
// ==================================================
// UART link
// 8N1 receiver and transmitter, LSB first, one bit period
// ==================================================
`include "matrix_cfg.svh"

module uart_link (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       uart_rx,
    output logic [7:0] rx_data,
    output logic       rx_done,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx_busy,
    output logic       uart_tx
);

    localparam int CPB = `MATRIX_CLKS_PER_BIT;
    localparam int CW  = $clog2(CPB);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e     rx_state;
    logic [1:0]    rx_sync;
    logic [CW-1:0] rx_cnt;
    logic [2:0]    rx_bit;
    logic [7:0]    rx_shift;
    logic [CW-1:0] tx_cnt;
    logic [3:0]    tx_bit;
    logic [9:0]    tx_frame;

    // ================================================
    // Receiver
    // ================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_sync  <= 2'b11;
            rx_state <= RX_IDLE;
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_shift <= '0;
            rx_data  <= '0;
            rx_done  <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], uart_rx};
            rx_done <= 1'b0;
            case (rx_state)
                RX_IDLE: begin
                    rx_cnt <= '0;
                    if (!rx_sync[1]) begin
                        rx_state <= RX_START;
                    end
                end
                RX_START: begin
                    // Half a bit in, confirm the start bit is still low
                    if (rx_cnt == CW'(CPB / 2 - 1)) begin
                        rx_cnt   <= '0;
                        rx_bit   <= '0;
                        rx_state <= rx_sync[1] ? RX_IDLE : RX_DATA;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (rx_cnt == CW'(CPB - 1)) begin
                        rx_cnt   <= '0;
                        rx_shift <= {rx_sync[1], rx_shift[7:1]};
                        rx_bit   <= rx_bit + 1'b1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= RX_STOP;
                        end
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                default: begin
                    if (rx_cnt == CW'(CPB - 1)) begin
                        rx_state <= RX_IDLE;
                        // Framing error drops the byte
                        if (rx_sync[1]) begin
                            rx_data <= rx_shift;
                            rx_done <= 1'b1;
                        end
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // ================================================
    // Transmitter
    // ================================================
    assign uart_tx = tx_frame[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_frame <= '1;
            tx_busy  <= 1'b0;
            tx_cnt   <= '0;
            tx_bit   <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_frame <= {1'b1, tx_data, 1'b0};
                tx_busy  <= 1'b1;
                tx_cnt   <= '0;
                tx_bit   <= '0;
            end
        end else if (tx_cnt == CW'(CPB - 1)) begin
            tx_cnt   <= '0;
            tx_frame <= {1'b1, tx_frame[9:1]};
            // Ten bits out means the stop bit is done
            if (tx_bit == 4'd9) begin
                tx_busy <= 1'b0;
            end else begin
                tx_bit <= tx_bit + 1'b1;
            end
        end else begin
            tx_cnt <= tx_cnt + 1'b1;
        end
    end

endmodule
